// File: decode_top.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
control_unit.sv
imm_extend.sv
regfile.sv
csr_file.sv
instr_decode.sv
decode_top.sv
decode_chk.sv
tb_decode_top.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f decode_top.f \
        --top-module tb_decode_top -o tb_decode_top; then
    echo "verilator build failed"
    exit 1
fi

if ! out=$(./obj_dir/tb_decode_top); then
    printf '%s\n' "$out"
    echo "simulation exited with an error status"
    exit 1
fi
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1

// File: tb_decode_model.svh
`ifndef tb_decode_model_svh
`define tb_decode_model_svh

// ******************************
// Reference model state.
// ******************************
logic [31:0] m_regs [0:31];
logic [31:0] m_mstatus;
logic [31:0] m_mscratch;
logic [31:0] m_result_bytes;
logic [31:0] m_cycle;

task automatic model_reset();
    m_mstatus      = 32'd0;
    m_mscratch     = 32'd0;
    m_result_bytes = 32'd0;
    m_cycle        = 32'd0;
endtask

function automatic alu_op_e model_alu(input logic [2:0] f3, input logic b30,
                                      input logic is_reg);
    alu_op_e op;
    case (f3)
        3'd0:    op = (is_reg && b30) ? alu_sub : alu_add;
        3'd1:    op = alu_sll;
        3'd2:    op = alu_slt;
        3'd3:    op = alu_sltu;
        3'd4:    op = alu_xor;
        3'd5:    op = b30 ? alu_sra : alu_srl;
        3'd6:    op = alu_or;
        default: op = alu_and;
    endcase
    return op;
endfunction

// Legal-instruction decode, before the fetch valid is applied.
function automatic decode_ctrl_t model_ctrl(input logic [31:0] ins);
    decode_ctrl_t c;
    logic [7:0]   flags;
    c        = '0;
    c.valid  = 1'b1;
    c.alu_op = alu_add;
    // Columns: reg_write, mem_write, mem_read, branch, jump, alu_src, result_src.
    case (ins[6:0])
        op_lui:    flags = 8'b1_0_0_0_0_1_00;
        op_auipc:  flags = 8'b1_0_0_0_0_1_00;
        op_jal:    flags = 8'b1_0_0_0_1_0_10;
        op_jalr:   flags = 8'b1_0_0_0_1_1_10;
        op_branch: flags = 8'b0_0_0_1_0_0_00;
        op_load:   flags = 8'b1_0_1_0_0_1_01;
        op_store:  flags = 8'b0_1_0_0_0_1_00;
        op_imm:    flags = 8'b1_0_0_0_0_1_00;
        op_reg:    flags = 8'b1_0_0_0_0_0_00;
        op_system: begin
            if (ins[14:12] == f3_csrrw || ins[14:12] == f3_csrrwi) begin
                flags    = 8'b1_0_0_0_0_0_11;
                c.csr_op = 1'b1;
            end else begin
                flags   = 8'd0;
                c.valid = 1'b0;
            end
        end
        default: begin
            flags   = 8'd0;
            c.valid = 1'b0;
        end
    endcase
    {c.reg_write, c.mem_write, c.mem_read, c.branch, c.jump, c.alu_src, c.result_src} = flags;
    case (ins[6:0])
        op_lui:    c.alu_op = alu_lui;
        op_branch: c.alu_op = alu_sub;
        op_imm:    c.alu_op = model_alu(ins[14:12], ins[30], 1'b0);
        op_reg:    c.alu_op = model_alu(ins[14:12], ins[30], 1'b1);
        default: ;
    endcase
    return c;
endfunction

function automatic logic [31:0] model_imm(input logic [31:0] ins);
    case (ins[6:0])
        op_lui, op_auipc: return {ins[31:12], 12'b0};
        op_jal:    return {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        op_branch: return {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        op_store:  return {{21{ins[31]}}, ins[30:25], ins[11:7]};
        default:   return {{21{ins[31]}}, ins[30:20]};
    endcase
endfunction

function automatic logic [31:0] model_read(input logic [4:0] a, input wb_t w);
    if (a == 5'd0) return 32'd0;
    if (w.reg_write && w.rd == a) return w.result;
    return m_regs[a];
endfunction

function automatic logic [31:0] model_csr_read(input logic [11:0] addr);
    case (addr)
        csr_mstatus:      return m_mstatus;
        csr_mscratch:     return m_mscratch;
        csr_result_bytes: return m_result_bytes;
        csr_cycle:        return m_cycle;
        default:          return 32'd0;
    endcase
endfunction

// Predicts the boundary contents for one input and applies the edge to the model.
task automatic model_predict(input fetch_data_t f, input wb_t w,
                             output decode_ctrl_t ec, output decode_data_t ed);
    logic [31:0]  ins;
    logic [31:0]  wdata;
    logic [11:0]  addr;
    decode_ctrl_t c;
    ins = f.instr;
    c   = model_ctrl(ins);
    ec  = '0;
    if (f.valid && c.valid) begin
        ec = c;
    end
    ed.pc        = f.pc;
    ed.pc_plus4  = f.pc_plus4;
    ed.rs1       = ins[19:15];
    ed.rs2       = ins[24:20];
    ed.rd        = ins[11:7];
    ed.rd1       = model_read(ins[19:15], w);
    ed.rd2       = model_read(ins[24:20], w);
    ed.imm_ext   = model_imm(ins);
    addr         = ed.imm_ext[11:0];
    ed.csr_rdata = model_csr_read(addr);
    wdata = (ins[14:12] == f3_csrrwi) ? {27'd0, ins[19:15]} : ed.rd1;
    if (ec.csr_op) begin
        case (addr)
            csr_mstatus:      m_mstatus      = wdata;
            csr_mscratch:     m_mscratch     = wdata;
            csr_result_bytes: m_result_bytes = wdata;
            default: ;
        endcase
    end
    if (w.reg_write && w.rd != 5'd0) begin
        m_regs[w.rd] = w.result;
    end
endtask

`endif

// File: tb_decode_top.sv
`timescale 1ns/10ps

module tb_decode_top import isa_pkg::*, pipe_pkg::*; ();

    localparam int clk_period   = 100;
    localparam int reset_cycles = 10;
    localparam int n_random     = 400;
    localparam int n_invalid    = 60;
    localparam int n_cycle      = 20;
    // Reset plus its release, 32 register writes, and one flush step per test.
    localparam int total_cycles = reset_cycles + 1 + 33 + n_random + n_invalid + n_cycle + 3;

    localparam logic [6:0] opcodes [0:10] = '{op_lui, op_auipc, op_jal, op_jalr,
        op_branch, op_load, op_store, op_imm, op_reg, op_system, 7'b1111111};
    localparam logic [11:0] csr_addrs [0:4] = '{csr_mstatus, csr_mscratch,
        csr_result_bytes, csr_cycle, 12'h123};

    logic            clk;
    logic            arst_n;
    fetch_data_t     fetch;
    wb_t             wb;
    decode_ctrl_t    dec_ctrl;
    decode_data_t    dec_data;
    logic [xlen-1:0] status;
    logic [xlen-1:0] result_bytes;

    decode_ctrl_t    exp_ctrl;
    decode_data_t    exp_data;
    logic            have_exp;
    int              total_checks;
    int              total_errors;
    int              test_checks;
    int              test_errors;

    `include "tb_decode_model.svh"

    decode_top DUT (
        .clk          (clk),
        .arst_n       (arst_n),
        .fetch        (fetch),
        .wb           (wb),
        .dec_ctrl     (dec_ctrl),
        .dec_data     (dec_data),
        .status       (status),
        .result_bytes (result_bytes)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        test_checks++;
        total_checks++;
        if (actual !== expected) begin
            test_errors++;
            total_errors++;
            $display("error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    // One cycle: check the previous result, then drive and predict the next input.
    task automatic step(input fetch_data_t f, input wb_t w);
        @(negedge clk);
        m_cycle = m_cycle + 32'd1;
        if (have_exp) begin
            compare_value("dec_ctrl", 32'(exp_ctrl), 32'(dec_ctrl));
            compare_value("dec_data.pc", exp_data.pc, dec_data.pc);
            compare_value("dec_data.pc_plus4", exp_data.pc_plus4, dec_data.pc_plus4);
            compare_value("dec_data.rs1", 32'(exp_data.rs1), 32'(dec_data.rs1));
            compare_value("dec_data.rs2", 32'(exp_data.rs2), 32'(dec_data.rs2));
            compare_value("dec_data.rd", 32'(exp_data.rd), 32'(dec_data.rd));
            compare_value("dec_data.rd1", exp_data.rd1, dec_data.rd1);
            compare_value("dec_data.rd2", exp_data.rd2, dec_data.rd2);
            compare_value("dec_data.imm_ext", exp_data.imm_ext, dec_data.imm_ext);
            compare_value("dec_data.csr_rdata", exp_data.csr_rdata, dec_data.csr_rdata);
        end
        compare_value("status", m_mstatus, status);
        compare_value("result_bytes", m_result_bytes, result_bytes);
        fetch = f;
        wb    = w;
        model_predict(f, w, exp_ctrl, exp_data);
        have_exp = 1'b1;
    endtask

    function automatic logic [31:0] random_instr(input logic force_csr);
        logic [31:0] ins;
        ins        = $urandom;
        ins[6:0]   = opcodes[$urandom % 11];
        ins[11:7]  = 5'($urandom % 8);
        ins[19:15] = 5'($urandom % 8);
        ins[24:20] = 5'($urandom % 8);
        if (force_csr) begin
            ins[6:0] = op_system;
        end
        if (ins[6:0] == op_system) begin
            // Mostly the two CSR ops, now and then an unsupported funct3.
            case ($urandom % 4)
                0, 1:    ins[14:12] = f3_csrrw;
                2:       ins[14:12] = f3_csrrwi;
                default: ins[14:12] = force_csr ? f3_csrrwi : 3'($urandom);
            endcase
            ins[31:20] = csr_addrs[$urandom % 5];
        end
        return ins;
    endfunction

    function automatic fetch_data_t random_fetch(input logic valid, input logic force_csr);
        fetch_data_t f;
        f.valid    = valid;
        f.instr    = random_instr(force_csr);
        f.pc       = $urandom & 32'hffff_fffc;
        f.pc_plus4 = f.pc + 32'd4;
        return f;
    endfunction

    function automatic wb_t random_wb();
        wb_t w;
        w.rd        = 5'($urandom % 8);
        w.result    = $urandom;
        w.reg_write = 1'($urandom % 2);
        return w;
    endfunction

    initial begin
        fetch_data_t f;
        wb_t         w;
        void'($urandom(32'he388));
        clk          = 1'b0;
        arst_n       = 1'b0;
        fetch        = '0;
        wb           = '0;
        exp_ctrl     = '0;
        exp_data     = '0;
        have_exp     = 1'b0;
        total_checks = 0;
        total_errors = 0;
        test_checks  = 0;
        test_errors  = 0;

        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        compare_value("dec_ctrl", 32'd0, 32'(dec_ctrl));
        compare_value("status", 32'd0, status);
        compare_value("result_bytes", 32'd0, result_bytes);
        arst_n = 1'b1;
        model_reset();
        finish_test("reset");

        // x0 gets a write too, which must be dropped.
        for (int r = 0; r < 32; r++) begin
            w.rd        = 5'(r);
            w.result    = $urandom;
            w.reg_write = 1'b1;
            step('0, w);
        end
        step('0, '0);
        finish_test("register_init");

        for (int n = 0; n < n_random; n++) begin
            step(random_fetch(($urandom % 8) != 0, 1'b0), random_wb());
        end
        step('0, '0);
        finish_test("random_mix");

        for (int n = 0; n < n_invalid; n++) begin
            step(random_fetch(1'b0, ($urandom % 2) == 1), random_wb());
        end
        step('0, '0);
        finish_test("invalid_input");

        for (int n = 0; n < n_cycle; n++) begin
            f = random_fetch(1'b1, 1'b1);
            f.instr.i.imm_11_0 = csr_cycle;
            step(f, random_wb());
        end
        step('0, '0);
        finish_test("cycle_counter");

        $display("summary: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #((total_cycles + 20) * clk_period);
        $display("watchdog: tests did not finish within %0d cycles", total_cycles + 20);
        $display("Checks failed");
        $finish;
    end

endmodule

// File: decode_chk.sv
`timescale 1ns/10ps

module decode_chk import isa_pkg::*, pipe_pkg::*; (
    input logic         clk,
    input logic         arst_n,
    input fetch_data_t  fetch,
    input decode_ctrl_t dec_ctrl,
    input decode_data_t dec_data
);

    a_reset_clear: assert property (@(posedge clk) !arst_n |-> dec_ctrl == '0)
        else $error("decode control not cleared in reset");

    // An invalid slot carries no control.
    a_invalid_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        !dec_ctrl.valid |-> {dec_ctrl.reg_write, dec_ctrl.mem_write, dec_ctrl.mem_read,
                             dec_ctrl.branch, dec_ctrl.jump, dec_ctrl.csr_op} == '0)
        else $error("control bit set while decode valid is low");

    a_rd_follows: assert property (@(posedge clk) disable iff (!arst_n)
        dec_ctrl.valid |-> dec_data.rd == $past(fetch.instr.r.rd))
        else $error("decoded rd does not match the previous instruction");

endmodule

bind instr_decode decode_chk u_decode_chk (
    .clk      (clk),
    .arst_n   (arst_n),
    .fetch    (fetch),
    .dec_ctrl (dec_ctrl),
    .dec_data (dec_data)
);

// File: decode_top.sv
`timescale 1ns/10ps

module decode_top import isa_pkg::*, pipe_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  fetch_data_t     fetch,
    input  wb_t             wb,
    output decode_ctrl_t    dec_ctrl,
    output decode_data_t    dec_data,
    output logic [xlen-1:0] status,
    output logic [xlen-1:0] result_bytes
);

    instr_decode u_instr_decode (
        .clk          (clk),
        .arst_n       (arst_n),
        .fetch        (fetch),
        .wb           (wb),
        .dec_ctrl     (dec_ctrl),
        .dec_data     (dec_data),
        .status       (status),
        .result_bytes (result_bytes)
    );

endmodule

// File: instr_decode.sv
`timescale 1ns/10ps

module instr_decode import isa_pkg::*, pipe_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  fetch_data_t     fetch,
    input  wb_t             wb,
    output decode_ctrl_t    dec_ctrl,
    output decode_data_t    dec_data,
    output logic [xlen-1:0] status,
    output logic [xlen-1:0] result_bytes
);

    decode_ctrl_t    ctrl_d;
    decode_ctrl_t    ctrl_n;
    decode_data_t    data_n;
    imm_src_e        imm_src;
    csr_ctrl_t       csr_ctrl;
    logic [xlen-1:0] rd1;
    logic [xlen-1:0] rd2;
    logic [xlen-1:0] imm_ext;
    logic [xlen-1:0] csr_wdata;
    logic [xlen-1:0] csr_rdata;
    logic            issue;
    logic            csr_we;

    // ******************************
    // Decode blocks.
    // ******************************
    control_unit u_control_unit (
        .instr    (fetch.instr),
        .ctrl     (ctrl_d),
        .imm_src  (imm_src),
        .csr_ctrl (csr_ctrl)
    );

    regfile u_regfile (
        .clk (clk),
        .a1  (fetch.instr.r.rs1),
        .a2  (fetch.instr.r.rs2),
        .wb  (wb),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    imm_extend u_imm_extend (
        .instr   (fetch.instr),
        .imm_src (imm_src),
        .imm_ext (imm_ext)
    );

    // csrrwi takes the rs1 field as a zero-extended immediate.
    assign csr_wdata = (csr_ctrl.csr_src == csr_src_imm)
                     ? {{(xlen - reg_addr_w){1'b0}}, fetch.instr.r.rs1}
                     : rd1;

    assign issue  = fetch.valid & ctrl_d.valid;
    assign csr_we = issue & csr_ctrl.csr_write;

    csr_file u_csr_file (
        .clk          (clk),
        .arst_n       (arst_n),
        .we           (csr_we),
        .addr         (imm_ext[11:0]),
        .wdata        (csr_wdata),
        .rdata        (csr_rdata),
        .status       (status),
        .result_bytes (result_bytes)
    );

    // ******************************
    // Decode/execute boundary.
    // ******************************
    always_comb begin
        ctrl_n = '0;
        if (issue) begin
            ctrl_n = ctrl_d;
        end
    end

    always_comb begin
        data_n.pc        = fetch.pc;
        data_n.pc_plus4  = fetch.pc_plus4;
        data_n.rs1       = fetch.instr.r.rs1;
        data_n.rs2       = fetch.instr.r.rs2;
        data_n.rd        = fetch.instr.r.rd;
        data_n.rd1       = rd1;
        data_n.rd2       = rd2;
        data_n.imm_ext   = imm_ext;
        data_n.csr_rdata = csr_rdata;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_ctrl <= '0;
        end else begin
            dec_ctrl <= ctrl_n;
        end
    end

    always_ff @(posedge clk) begin
        dec_data <= data_n;
    end

endmodule

// File: csr_file.sv
`timescale 1ns/10ps

module csr_file import isa_pkg::*, pipe_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            we,
    input  logic [11:0]     addr,
    input  logic [xlen-1:0] wdata,
    output logic [xlen-1:0] rdata,
    output logic [xlen-1:0] status,
    output logic [xlen-1:0] result_bytes
);

    logic [xlen-1:0] mstatus_q;
    logic [xlen-1:0] mscratch_q;
    logic [xlen-1:0] result_bytes_q;
    logic [xlen-1:0] cycle_q;

    // Cycle is read-only, so it has no write case.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mstatus_q      <= '0;
            mscratch_q     <= '0;
            result_bytes_q <= '0;
            cycle_q        <= '0;
        end else begin
            cycle_q <= cycle_q + 1'b1;
            if (we) begin
                case (addr)
                    csr_mstatus:      mstatus_q      <= wdata;
                    csr_mscratch:     mscratch_q     <= wdata;
                    csr_result_bytes: result_bytes_q <= wdata;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (addr)
            csr_mstatus:      rdata = mstatus_q;
            csr_mscratch:     rdata = mscratch_q;
            csr_result_bytes: rdata = result_bytes_q;
            csr_cycle:        rdata = cycle_q;
            default:          rdata = '0;
        endcase
    end

    assign status       = mstatus_q;
    assign result_bytes = result_bytes_q;

endmodule

// File: regfile.sv
`timescale 1ns/10ps

module regfile import isa_pkg::*, pipe_pkg::*; (
    input  logic                  clk,
    input  logic [reg_addr_w-1:0] a1,
    input  logic [reg_addr_w-1:0] a2,
    input  wb_t                   wb,
    output logic [xlen-1:0]       rd1,
    output logic [xlen-1:0]       rd2
);

    logic [xlen-1:0] regs [0:31];

    // x0 reads zero. A write-back to the same register is forwarded.
    function automatic logic [xlen-1:0] read_port(input logic [reg_addr_w-1:0] a);
        logic [xlen-1:0] value;
        if (a == '0)                           value = '0;
        else if (wb.reg_write && wb.rd == a)   value = wb.result;
        else                                   value = regs[a];
        return value;
    endfunction

    always_ff @(posedge clk) begin
        if (wb.reg_write && wb.rd != '0) begin
            regs[wb.rd] <= wb.result;
        end
    end

    always_comb begin
        rd1 = read_port(a1);
        rd2 = read_port(a2);
    end

endmodule

// File: imm_extend.sv
`timescale 1ns/10ps

module imm_extend import isa_pkg::*; (
    input  instr_u          instr,
    input  imm_src_e        imm_src,
    output logic [xlen-1:0] imm_ext
);

    always_comb begin
        case (imm_src)
            imm_i: imm_ext = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
            imm_s: imm_ext = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5,
                              instr.s.imm_4_0};
            // Branch offsets are in halfwords.
            imm_b: imm_ext = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                              instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
            imm_u: imm_ext = {instr.u.imm_31_12, 12'b0};
            imm_j: imm_ext = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                              instr.j.imm_11, instr.j.imm_10_1, 1'b0};
            default: imm_ext = '0;
        endcase
    end

endmodule

// File: control_unit.sv
`timescale 1ns/10ps

module control_unit import isa_pkg::*, pipe_pkg::*; (
    input  instr_u       instr,
    output decode_ctrl_t ctrl,
    output imm_src_e     imm_src,
    output csr_ctrl_t    csr_ctrl
);

    // ALU operation for the register and immediate arithmetic groups.
    function automatic alu_op_e alu_from_funct(input logic [2:0] funct3,
                                               input logic       funct7_5,
                                               input logic       is_reg);
        alu_op_e op;
        case (funct3)
            3'b000: begin
                if (is_reg && funct7_5) op = alu_sub;
                else                    op = alu_add;
            end
            3'b001: op = alu_sll;
            3'b010: op = alu_slt;
            3'b011: op = alu_sltu;
            3'b100: op = alu_xor;
            3'b101: begin
                if (funct7_5) op = alu_sra;
                else          op = alu_srl;
            end
            3'b110: op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    // Here valid flags a legal instruction; the stage merges it with fetch.valid.
    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = alu_add;
        imm_src     = imm_i;
        csr_ctrl    = '0;
        case (instr.r.opcode)
            op_lui: begin
                ctrl.valid     = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = alu_lui;
                imm_src        = imm_u;
            end
            op_auipc: begin
                ctrl.valid     = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                imm_src        = imm_u;
            end
            op_jal: begin
                ctrl.valid      = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.jump       = 1'b1;
                ctrl.result_src = res_pc4;
                imm_src         = imm_j;
            end
            op_jalr: begin
                ctrl.valid      = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.jump       = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.result_src = res_pc4;
            end
            op_branch: begin
                ctrl.valid  = 1'b1;
                ctrl.branch = 1'b1;
                ctrl.alu_op = alu_sub;
                imm_src     = imm_b;
            end
            op_load: begin
                ctrl.valid      = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.result_src = res_mem;
            end
            op_store: begin
                ctrl.valid     = 1'b1;
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                imm_src        = imm_s;
            end
            op_imm: begin
                ctrl.valid     = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = alu_from_funct(instr.r.funct3, instr.r.funct7[5], 1'b0);
            end
            op_reg: begin
                ctrl.valid     = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_from_funct(instr.r.funct3, instr.r.funct7[5], 1'b1);
            end
            op_system: begin
                if (instr.r.funct3 == f3_csrrw || instr.r.funct3 == f3_csrrwi) begin
                    ctrl.valid         = 1'b1;
                    ctrl.reg_write     = 1'b1;
                    ctrl.result_src    = res_csr;
                    ctrl.csr_op        = 1'b1;
                    csr_ctrl.csr_write = 1'b1;
                    if (instr.r.funct3 == f3_csrrwi) csr_ctrl.csr_src = csr_src_imm;
                    else                             csr_ctrl.csr_src = csr_src_reg;
                end
            end
            default: begin
                ctrl.valid = 1'b0;
            end
        endcase
    end

endmodule

// File: pipe_pkg.sv
package pipe_pkg;

    import isa_pkg::*;

    // ******************************
    // CSR map.
    // ******************************
    localparam logic [11:0] csr_mstatus      = 12'h300;
    localparam logic [11:0] csr_mscratch     = 12'h340;
    localparam logic [11:0] csr_result_bytes = 12'h801;
    localparam logic [11:0] csr_cycle        = 12'hC00;

    localparam logic csr_src_reg = 1'b0;
    localparam logic csr_src_imm = 1'b1;

    // Result select for write-back.
    localparam logic [1:0] res_alu = 2'd0;
    localparam logic [1:0] res_mem = 2'd1;
    localparam logic [1:0] res_pc4 = 2'd2;
    localparam logic [1:0] res_csr = 2'd3;

    typedef struct packed {
        logic            valid;
        instr_u          instr;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] pc_plus4;
    } fetch_data_t;

    typedef struct packed {
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       result;
        logic                  reg_write;
    } wb_t;

    typedef struct packed {
        logic       valid;
        logic       reg_write;
        logic       mem_write;
        logic       mem_read;
        logic       branch;
        logic       jump;
        logic       alu_src;
        alu_op_e    alu_op;
        logic [1:0] result_src;
        logic       csr_op;
    } decode_ctrl_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       pc_plus4;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       rd1;
        logic [xlen-1:0]       rd2;
        logic [xlen-1:0]       imm_ext;
        logic [xlen-1:0]       csr_rdata;
    } decode_data_t;

    typedef struct packed {
        logic csr_write;
        logic csr_src;
    } csr_ctrl_t;

endpackage

// File: isa_pkg.sv
package isa_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // ******************************
    // Opcodes and funct codes.
    // ******************************
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_system = 7'b1110011;

    localparam logic [2:0] f3_csrrw  = 3'b001;
    localparam logic [2:0] f3_csrrwi = 3'b101;

    typedef enum logic [2:0] {
        imm_i = 3'd0,
        imm_s = 3'd1,
        imm_b = 3'd2,
        imm_u = 3'd3,
        imm_j = 3'd4
    } imm_src_e;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9,
        alu_lui  = 4'd10  // passes operand b through
    } alu_op_e;

    // ******************************
    // Instruction formats.
    // ******************************
    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm_11_0;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_11_5;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_4_0;
        logic [6:0]            opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        logic [6:0]            opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]           imm_31_12;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                  imm_20;
        logic [9:0]            imm_10_1;
        logic                  imm_11;
        logic [7:0]            imm_19_12;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } j_fmt_t;

    // One instruction word, seen through each format.
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

endpackage
